// File: design/streamer_mem_pkg.sv
// Memory port types
package streamer_mem_pkg;

  // Word address and data widths of the shared port
  localparam int unsigned AddrW = 16;
  localparam int unsigned DataW = 32;

  // Request from the streamer towards memory
  typedef struct packed {
    logic             req;
    // High for a store
    logic             wen;
    logic [AddrW-1:0] addr;
    logic [DataW-1:0] wdata;
  } mem_req_t;

  // Grant and in-order read response
  typedef struct packed {
    logic             gnt;
    logic             r_valid;
    logic [DataW-1:0] r_data;
  } mem_rsp_t;

endpackage : streamer_mem_pkg

// File: design/streamer_cfg_pkg.sv
// Streamer job configuration
package streamer_cfg_pkg;

  import streamer_mem_pkg::*;

  // Stream length in words
  localparam int unsigned LenW = 12;

  // One strided stream
  typedef struct packed {
    logic [AddrW-1:0] base;
    logic [AddrW-1:0] stride;
    logic [LenW-1:0]  len;
  } stream_cfg_t;

  // Complete job for both loads and the store
  typedef struct packed {
    stream_cfg_t x;
    stream_cfg_t w;
    stream_cfg_t z;
    // Store channel wins over loads when set
    logic        z_priority;
  } streamer_cfg_t;

  // Channel ids on the shared port
  typedef enum logic [1:0] {
    STREAM_X = 2'd0,
    STREAM_W = 2'd1,
    STREAM_Z = 2'd2
  } stream_id_e;

endpackage : streamer_cfg_pkg

// File: design/stream_fifo.sv
// Stream FIFO with slot reservation
module stream_fifo #(
  parameter int unsigned Depth     = 4,
  parameter type         payload_t = logic
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     reserve_i,
  input  logic     push_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o,
  input  logic     ready_i,
  output logic     space_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  payload_t        mem_q [Depth];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q, resv_q;
  logic            pop, use_resv;

  assign pop      = valid_o & ready_i;
  // A push lands in a reserved slot if there is one
  assign use_resv = push_i & (resv_q != '0);
  assign valid_o  = (count_q != '0);
  assign data_o   = mem_q[rd_ptr_q];
  // Reserved slots count as occupied
  assign space_o  = (count_q + resv_q) < CntW'(Depth);

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      resv_q   <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      case ({reserve_i, use_resv})
        2'b10:   resv_q <= resv_q + 1'b1;
        2'b01:   resv_q <= resv_q - 1'b1;
        default: resv_q <= resv_q;
      endcase
    end
  end

endmodule : stream_fifo

// File: design/addr_counter.sv
// Strided address counter
module addr_counter
  import streamer_mem_pkg::*;
  import streamer_cfg_pkg::*;
(
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             start_i,
  input  stream_cfg_t      cfg_i,
  input  logic             advance_i,
  output logic [AddrW-1:0] addr_o,
  output logic             active_o,
  output logic             finished_o
);

  logic [AddrW-1:0] addr_q;
  logic [AddrW-1:0] stride_q;
  logic [LenW-1:0]  remaining_q;

  assign addr_o   = addr_q;
  assign active_o = (remaining_q != '0);
  // Not finished while the job fields are still being loaded
  assign finished_o = ~active_o & ~start_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      addr_q      <= '0;
      stride_q    <= '0;
      remaining_q <= '0;
    end else if (start_i) begin
      addr_q      <= cfg_i.base;
      stride_q    <= cfg_i.stride;
      remaining_q <= cfg_i.len;
    end else if (advance_i && active_o) begin
      addr_q      <= addr_q + stride_q;
      remaining_q <= remaining_q - 1'b1;
    end
  end

endmodule : addr_counter

// File: design/mem_arbiter.sv
// Memory port arbiter
module mem_arbiter
  import streamer_mem_pkg::*;
  import streamer_cfg_pkg::*;
#(
  parameter int unsigned MaxOutstanding = 4
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             z_priority_i,
  input  logic             x_req_i,
  input  logic             w_req_i,
  input  logic             z_req_i,
  input  logic [AddrW-1:0] x_addr_i,
  input  logic [AddrW-1:0] w_addr_i,
  input  logic [AddrW-1:0] z_addr_i,
  input  logic [DataW-1:0] z_wdata_i,
  output logic             x_gnt_o,
  output logic             w_gnt_o,
  output logic             z_gnt_o,
  output logic             x_fill_o,
  output logic             w_fill_o,
  output logic [DataW-1:0] r_data_o,
  output logic             idle_o,
  output mem_req_t         mem_req_o,
  input  mem_rsp_t         mem_rsp_i
);

  localparam int unsigned PtrW = (MaxOutstanding > 1) ? $clog2(MaxOutstanding) : 1;
  localparam int unsigned CntW = $clog2(MaxOutstanding + 1);

  // Ids of reads still waiting for their response
  stream_id_e      id_q [MaxOutstanding];
  logic [PtrW-1:0] wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            q_full, x_ok, w_ok;
  logic            x_sel, w_sel, z_sel;
  logic            lock_q, push_id, pop_id;
  stream_id_e      lock_id_q, win_id, head_id;

  assign q_full = (count_q == CntW'(MaxOutstanding));
  assign x_ok   = x_req_i & ~q_full;
  assign w_ok   = w_req_i & ~q_full;

  // Fixed priority; a request left waiting for gnt keeps the port
  always_comb begin
    x_sel = 1'b0;
    w_sel = 1'b0;
    z_sel = 1'b0;
    if (lock_q) begin
      x_sel = (lock_id_q == STREAM_X);
      w_sel = (lock_id_q == STREAM_W);
      z_sel = (lock_id_q == STREAM_Z);
    end else if (z_priority_i && z_req_i) begin
      z_sel = 1'b1;
    end else if (x_ok) begin
      x_sel = 1'b1;
    end else if (w_ok) begin
      w_sel = 1'b1;
    end else begin
      z_sel = z_req_i;
    end
  end

  assign win_id = x_sel ? STREAM_X : (w_sel ? STREAM_W : STREAM_Z);

  assign mem_req_o.req   = x_sel | w_sel | z_sel;
  assign mem_req_o.wen   = z_sel;
  assign mem_req_o.addr  = x_sel ? x_addr_i : (w_sel ? w_addr_i : z_addr_i);
  assign mem_req_o.wdata = z_wdata_i;

  assign x_gnt_o = x_sel & mem_rsp_i.gnt;
  assign w_gnt_o = w_sel & mem_rsp_i.gnt;
  assign z_gnt_o = z_sel & mem_rsp_i.gnt;

  // Responses come back in grant order
  assign push_id  = x_gnt_o | w_gnt_o;
  assign pop_id   = mem_rsp_i.r_valid;
  assign head_id  = id_q[rd_ptr_q];
  assign x_fill_o = pop_id & (head_id == STREAM_X);
  assign w_fill_o = pop_id & (head_id == STREAM_W);
  assign r_data_o = mem_rsp_i.r_data;
  assign idle_o   = (count_q == '0);

  always_ff @(posedge clk_i) begin
    if (push_id) begin
      id_q[wr_ptr_q] <= win_id;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      lock_q    <= 1'b0;
      lock_id_q <= STREAM_X;
    end else begin
      lock_q    <= mem_req_o.req & ~mem_rsp_i.gnt;
      lock_id_q <= win_id;
      if (push_id) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(MaxOutstanding - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_id) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(MaxOutstanding - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_id, pop_id})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule : mem_arbiter

// File: design/streamer_ctrl_fsm.sv
// Streamer job control
module streamer_ctrl_fsm (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic start_i,
  input  logic all_finished_i,
  output logic start_o,
  output logic busy_o,
  output logic done_o
);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } state_e;

  state_e state_q, state_d;
  logic   start_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = RUN;
        end
      end
      RUN: begin
        if (all_finished_i) begin
          state_d = DONE;
        end
      end
      // Single cycle to flag completion
      DONE:    state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      start_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Starts outside IDLE are dropped
      start_q <= (state_q == IDLE) & start_i;
    end
  end

  assign start_o = start_q;
  assign busy_o  = (state_q == RUN);
  assign done_o  = (state_q == DONE);

endmodule : streamer_ctrl_fsm

// File: design/streamer_top.sv
// Matrix streamer top level
module streamer_top
  import streamer_mem_pkg::*;
  import streamer_cfg_pkg::*;
#(
  parameter int unsigned LoadFifoDepth  = 4,
  parameter int unsigned StoreFifoDepth = 2,
  parameter int unsigned MaxOutstanding = 4
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             start_i,
  input  streamer_cfg_t    cfg_i,
  output logic             busy_o,
  output logic             done_o,
  output logic             x_valid_o,
  output logic [DataW-1:0] x_data_o,
  input  logic             x_ready_i,
  output logic             w_valid_o,
  output logic [DataW-1:0] w_data_o,
  input  logic             w_ready_i,
  input  logic             z_valid_i,
  input  logic [DataW-1:0] z_data_i,
  output logic             z_ready_o,
  output mem_req_t         mem_req_o,
  input  mem_rsp_t         mem_rsp_i
);

  logic             job_start, all_finished, arb_idle;
  logic [AddrW-1:0] x_addr, w_addr, z_addr;
  logic             x_active, w_active, z_active;
  logic             x_fin, w_fin, z_fin;
  logic             x_space, w_space, z_space;
  logic             x_gnt, w_gnt, z_gnt, x_fill, w_fill;
  logic [DataW-1:0] r_data, z_wdata;
  logic             z_fifo_valid, z_push;

  assign all_finished = x_fin & w_fin & z_fin & arb_idle;

  // Z words are taken only while the job still has writes to issue
  assign z_ready_o = z_space & z_active;
  assign z_push    = z_valid_i & z_ready_o;

  streamer_ctrl_fsm u_ctrl (
    .clk_i, .arst_n_i, .start_i,
    .all_finished_i ( all_finished ),
    .start_o        ( job_start    ),
    .busy_o, .done_o
  );

  addr_counter u_x_cnt (
    .clk_i, .arst_n_i, .start_i ( job_start ), .cfg_i ( cfg_i.x ),
    .advance_i ( x_gnt ), .addr_o ( x_addr ), .active_o ( x_active ), .finished_o ( x_fin )
  );

  addr_counter u_w_cnt (
    .clk_i, .arst_n_i, .start_i ( job_start ), .cfg_i ( cfg_i.w ),
    .advance_i ( w_gnt ), .addr_o ( w_addr ), .active_o ( w_active ), .finished_o ( w_fin )
  );

  addr_counter u_z_cnt (
    .clk_i, .arst_n_i, .start_i ( job_start ), .cfg_i ( cfg_i.z ),
    .advance_i ( z_gnt ), .addr_o ( z_addr ), .active_o ( z_active ), .finished_o ( z_fin )
  );

  // Load FIFOs reserve a slot on grant and fill on response
  stream_fifo #(.Depth(LoadFifoDepth), .payload_t(logic [DataW-1:0])) u_x_fifo (
    .clk_i, .arst_n_i, .reserve_i ( x_gnt ), .push_i ( x_fill ), .data_i ( r_data ),
    .valid_o ( x_valid_o ), .data_o ( x_data_o ), .ready_i ( x_ready_i ), .space_o ( x_space )
  );

  stream_fifo #(.Depth(LoadFifoDepth), .payload_t(logic [DataW-1:0])) u_w_fifo (
    .clk_i, .arst_n_i, .reserve_i ( w_gnt ), .push_i ( w_fill ), .data_i ( r_data ),
    .valid_o ( w_valid_o ), .data_o ( w_data_o ), .ready_i ( w_ready_i ), .space_o ( w_space )
  );

  stream_fifo #(.Depth(StoreFifoDepth), .payload_t(logic [DataW-1:0])) u_z_fifo (
    .clk_i, .arst_n_i, .reserve_i ( 1'b0 ), .push_i ( z_push ), .data_i ( z_data_i ),
    .valid_o ( z_fifo_valid ), .data_o ( z_wdata ), .ready_i ( z_gnt ), .space_o ( z_space )
  );

  mem_arbiter #(.MaxOutstanding(MaxOutstanding)) u_arb (
    .clk_i, .arst_n_i,
    .z_priority_i ( cfg_i.z_priority      ),
    .x_req_i      ( x_active & x_space    ),
    .w_req_i      ( w_active & w_space    ),
    .z_req_i      ( z_active & z_fifo_valid ),
    .x_addr_i     ( x_addr  ),
    .w_addr_i     ( w_addr  ),
    .z_addr_i     ( z_addr  ),
    .z_wdata_i    ( z_wdata ),
    .x_gnt_o      ( x_gnt   ),
    .w_gnt_o      ( w_gnt   ),
    .z_gnt_o      ( z_gnt   ),
    .x_fill_o     ( x_fill  ),
    .w_fill_o     ( w_fill  ),
    .r_data_o     ( r_data  ),
    .idle_o       ( arb_idle ),
    .mem_req_o, .mem_rsp_i
  );

endmodule : streamer_top

// File: sim/tb_streamer.sv
// Matrix streamer testbench
module tb_streamer
  import streamer_mem_pkg::*;
  import streamer_cfg_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumJobs     = 6;
  localparam int StallCycles = 300;

  logic             clk_i = 1'b0;
  logic             arst_n_i;
  logic             start_i;
  streamer_cfg_t    cfg_i;
  logic             busy_o, done_o;
  logic             x_valid_o, x_ready_i, w_valid_o, w_ready_i;
  logic [DataW-1:0] x_data_o, w_data_o, z_data_i;
  logic             z_valid_i, z_ready_o;
  mem_req_t         mem_req_o;
  mem_rsp_t         mem_rsp_i;

  // Memory contents and the expected image after each job
  logic [DataW-1:0] mem [65536];
  logic [DataW-1:0] exp_mem [65536];
  // Read data waiting to be returned, with the cycle it is due
  logic [DataW-1:0] pend_data [$];
  int               pend_due [$];
  streamer_cfg_t    jobs [NumJobs];
  logic [31:0]      lcg_state = 32'd35938;
  int               cyc, last_due, x_idx, w_idx, z_idx;
  int               rd_grants, wr_grants, done_total, x_stall_left;
  int               limit_cycles, n_checks, n_errors;

  streamer_top u_dut (
    .clk_i, .arst_n_i, .start_i, .cfg_i, .busy_o, .done_o,
    .x_valid_o, .x_data_o, .x_ready_i, .w_valid_o, .w_data_o, .w_ready_i,
    .z_valid_i, .z_data_i, .z_ready_o, .mem_req_o, .mem_rsp_i
  );

  always #2 clk_i = ~clk_i;

  function automatic logic [15:0] rand16();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[30:15];
  endfunction

  function automatic logic [31:0] rand32();
    logic [15:0] hi;
    hi = rand16();
    return {hi, rand16()};
  endfunction

  function automatic logic [AddrW-1:0] stream_addr(input stream_cfg_t c, input int idx);
    return AddrW'(c.base + idx * c.stride);
  endfunction

  // Loads read the low half of memory, stores write the upper half
  function automatic streamer_cfg_t make_job(input int j);
    streamer_cfg_t c;
    c.x.base     = AddrW'(rand16() % 16'h3000);
    c.x.stride   = AddrW'(1 + rand16() % 64);
    c.x.len      = LenW'(rand16() % 17);
    c.w.base     = AddrW'(16'h4000 + rand16() % 16'h3000);
    c.w.stride   = AddrW'(1 + rand16() % 64);
    c.w.len      = LenW'(rand16() % 17);
    c.z.base     = AddrW'(16'h8000 + rand16() % 16'h3000);
    c.z.stride   = AddrW'(1 + rand16() % 64);
    c.z.len      = LenW'(rand16() % 17);
    c.z_priority = j[0];
    return c;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("mismatch at %0t: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic take_load_word(input stream_cfg_t c, input logic [DataW-1:0] data,
                                inout int idx, input string name);
    if (idx < c.len) begin
      check(data, exp_mem[stream_addr(c, idx)], {name, " stream word"});
    end else begin
      n_errors++;
      $display("%s stream delivered a word beyond the job length at %0t", name, $time);
    end
    idx++;
  endtask

  // Memory model, stream sinks and Z source
  always @(posedge clk_i) begin : model
    int   due;
    logic z_take;
    if (arst_n_i) begin
      cyc = cyc + 1;
      if (mem_req_o.req && mem_rsp_i.gnt) begin
        if (mem_req_o.wen) begin
          mem[mem_req_o.addr] = mem_req_o.wdata;
          wr_grants++;
        end else begin
          due = cyc + 1 + rand16() % 4;
          if (due <= last_due) begin
            due = last_due + 1;
          end
          last_due = due;
          pend_data.push_back(mem[mem_req_o.addr]);
          pend_due.push_back(due);
          rd_grants++;
        end
      end
      // Responses leave in grant order
      if (pend_due.size() != 0 && pend_due[0] <= cyc) begin
        mem_rsp_i.r_valid <= 1'b1;
        mem_rsp_i.r_data  <= pend_data.pop_front();
        void'(pend_due.pop_front());
      end else begin
        mem_rsp_i.r_valid <= 1'b0;
      end
      if (x_valid_o && x_ready_i) begin
        take_load_word(cfg_i.x, x_data_o, x_idx, "X");
      end
      if (w_valid_o && w_ready_i) begin
        take_load_word(cfg_i.w, w_data_o, w_idx, "W");
      end
      z_take = z_valid_i & z_ready_o;
      if (z_take) begin
        exp_mem[stream_addr(cfg_i.z, z_idx)] = z_data_i;
        z_idx++;
      end
      // Z word holds until it is taken
      if (z_take || !z_valid_i) begin
        if (z_idx < cfg_i.z.len && rand16() % 2 == 0) begin
          z_valid_i <= 1'b1;
          z_data_i  <= rand32();
        end else begin
          z_valid_i <= 1'b0;
        end
      end
      if (done_o) begin
        done_total++;
        check(busy_o, 0, "busy_o while done_o is high");
        check(rd_grants, cfg_i.x.len + cfg_i.w.len, "read grants at done");
        check(wr_grants, cfg_i.z.len, "write grants at done");
        check(pend_due.size(), 0, "reads in flight at done");
      end
      mem_rsp_i.gnt <= (rand16() % 4 != 0);
      x_ready_i     <= (x_stall_left > 0) ? 1'b0 : (rand16() % 4 != 0);
      w_ready_i     <= (rand16() % 3 != 0);
      if (x_stall_left > 0) begin
        x_stall_left--;
      end
    end
  end

  initial begin : watchdog
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk_i);
    $display("timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin : main
    int total, diff, err_before;
    arst_n_i  = 1'b0;
    start_i   = 1'b0;
    cfg_i     = '0;
    x_ready_i = 1'b0;
    w_ready_i = 1'b0;
    z_valid_i = 1'b0;
    z_data_i  = '0;
    mem_rsp_i = '0;
    for (int a = 0; a < 65536; a++) begin
      mem[a] = rand32();
    end
    total = 0;
    for (int j = 0; j < NumJobs; j++) begin
      jobs[j] = make_job(j);
      total += jobs[j].x.len + jobs[j].w.len + jobs[j].z.len;
    end
    limit_cycles = 40 * total + (NumJobs / 3) * StallCycles + NumJobs * 80 + 500;

    repeat (5) @(posedge clk_i);
    arst_n_i <= 1'b1;
    // No start yet, so all outputs stay quiet
    err_before = n_errors;
    repeat (10) begin
      @(posedge clk_i);
      check({busy_o, done_o, x_valid_o, w_valid_o, z_ready_o, mem_req_o.req}, '0,
            "outputs after reset");
    end
    $display("reset test: %s", (n_errors == err_before) ? "ok" : "failed");

    for (int j = 0; j < NumJobs; j++) begin
      @(posedge clk_i);
      err_before = n_errors;
      x_idx      <= 0;
      w_idx      <= 0;
      z_idx      <= 0;
      rd_grants  = 0;
      wr_grants  = 0;
      exp_mem    = mem;
      // Every third job holds X back for a long stretch
      x_stall_left <= (j % 3 == 2) ? StallCycles : 0;
      cfg_i   <= jobs[j];
      start_i <= 1'b1;
      @(posedge clk_i);
      start_i <= 1'b0;
      @(posedge clk_i);
      check(busy_o, 1, "busy_o after start");
      // Second start while busy
      start_i <= 1'b1;
      @(posedge clk_i);
      start_i <= 1'b0;
      while (!done_o) @(posedge clk_i);
      // Load words still in the FIFOs drain after done
      while (x_valid_o || w_valid_o) @(posedge clk_i);
      repeat (12) @(posedge clk_i);
      check(done_total, j + 1, "done pulses so far");
      check(busy_o, 0, "busy_o after the job");
      check(x_idx, cfg_i.x.len, "X words delivered");
      check(w_idx, cfg_i.w.len, "W words delivered");
      check(z_idx, cfg_i.z.len, "Z words accepted");
      diff = 0;
      for (int a = 0; a < 65536; a++) begin
        if (mem[a] !== exp_mem[a]) begin
          diff++;
        end
      end
      check(diff, 0, "memory words that differ from the model");
      $display("job %0d: x %0d w %0d z %0d words, z_priority %0b, %s", j, cfg_i.x.len,
               cfg_i.w.len, cfg_i.z.len, cfg_i.z_priority,
               (n_errors == err_before) ? "ok" : "failed");
    end

    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : tb_streamer

// File: list.f
design/streamer_mem_pkg.sv
design/streamer_cfg_pkg.sv
design/stream_fifo.sv
design/addr_counter.sv
design/mem_arbiter.sv
design/streamer_ctrl_fsm.sv
design/streamer_top.sv
sim/tb_streamer.sv

// File: Bender.yml
package:
  name: matrix_streamer

sources:
  - files:
      - design/streamer_mem_pkg.sv
      - design/streamer_cfg_pkg.sv
      - design/stream_fifo.sv
      - design/addr_counter.sv
      - design/mem_arbiter.sv
      - design/streamer_ctrl_fsm.sv
      - design/streamer_top.sv
  - target: simulation
    files:
      - sim/tb_streamer.sv
